//--- hdl/bank_isu_pkg.sv
package bank_isu_pkg;

  // ------------------------------
  // queue and credit sizing
  // ------------------------------
  localparam int IQ_PTR_WIDTH = 3;
  localparam int IQ_DEPTH     = 1 << IQ_PTR_WIDTH;
  localparam int NUM_CH       = 3;
  localparam int CH_CREDITS   = 2;
  localparam int CREDIT_WIDTH = 2;

  typedef logic [IQ_PTR_WIDTH-1:0] iq_ptr_t;

  // hit-test unit opcode, bit 0 write, bit 1 evict
  typedef enum logic [1:0] {
    HTU_READ  = 2'd0,
    HTU_WRITE = 2'd1,
    HTU_EVICT = 2'd2
  } htu_op_e;

  // sram controller opcode
  typedef enum logic [1:0] {
    SC_WRITE         = 2'd0,
    SC_READ          = 2'd1,
    SC_READ_LINEFILL = 2'd2,
    SC_WRITE_BACK    = 2'd3
  } sc_op_e;

  // request from hit-test unit
  typedef struct packed {
    htu_op_e    op;
    logic [1:0] ch_id;
    logic [2:0] rob_id;
    logic [6:0] set_way_offset;
    logic [7:0] wbuffer_id;
    logic [1:0] cl_state0;
    logic [1:0] cl_state1;
    logic       need_linefill;
  } isu_req_t;

  // command to sram controller
  typedef struct packed {
    sc_op_e     opcode;
    logic [1:0] ch_id;
    logic [2:0] rob_num;
    logic [6:0] set_way_offset;
    logic [7:0] wbuffer_id;
    logic [1:0] cl_state0;
    logic [1:0] cl_state1;
  } sc_cmd_t;

endpackage

//--- hdl/iq_array.sv
module iq_array (
  input  logic                                                   clk_i,
  input  logic                                                   rst_n_i,
  input  logic                                                   alloc_i,
  input  bank_isu_pkg::iq_ptr_t                                  alloc_ptr_i,
  input  bank_isu_pkg::isu_req_t                                 alloc_req_i,
  input  logic                                                   alloc_inflight_i,
  input  logic                                                   issue_i,
  input  bank_isu_pkg::iq_ptr_t                                  issue_ptr_i,
  input  logic                                                   biu_rvalid_i,
  input  logic [5:0]                                             biu_rid_i,
  output logic [bank_isu_pkg::IQ_DEPTH-1:0]                      valid_vec_o,
  output logic [bank_isu_pkg::IQ_DEPTH-1:0]                      fill_ok_vec_o,
  output logic [bank_isu_pkg::IQ_DEPTH-1:0]                      evict_vec_o,
  output logic [bank_isu_pkg::NUM_CH-1:0][bank_isu_pkg::IQ_DEPTH-1:0] read_ch_vec_o,
  output bank_isu_pkg::sc_cmd_t                                  cmd_o
);

  import bank_isu_pkg::*;

  isu_req_t              entry_q [IQ_DEPTH];
  logic [IQ_DEPTH-1:0]   valid_q;
  logic [IQ_DEPTH-1:0]   fill_wait_q;
  logic [IQ_DEPTH-1:0]   fill_release;
  isu_req_t              sel_req;

  // ------------------------------
  // entry state
  // ------------------------------

  // line-fill tag match against bus read response
  always_comb begin
    for (int i = 0; i < IQ_DEPTH; i++) begin
      fill_release[i] = biu_rvalid_i & valid_q[i] & fill_wait_q[i]
                      & (entry_q[i].set_way_offset[5:0] == biu_rid_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q     <= '0;
      fill_wait_q <= '0;
    end else begin
      fill_wait_q <= fill_wait_q & ~fill_release;
      if (issue_i) begin
        valid_q[issue_ptr_i] <= 1'b0;
      end
      // alloc only lands on a free slot
      if (alloc_i) begin
        valid_q[alloc_ptr_i]     <= 1'b1;
        fill_wait_q[alloc_ptr_i] <= alloc_inflight_i;
      end
    end
  end

  // request payload
  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      entry_q[alloc_ptr_i] <= alloc_req_i;
    end
  end

  // ------------------------------
  // per-entry status vectors
  // ------------------------------
  always_comb begin
    for (int i = 0; i < IQ_DEPTH; i++) begin
      evict_vec_o[i] = valid_q[i] & (entry_q[i].op == HTU_EVICT);
      for (int c = 0; c < NUM_CH; c++) begin
        read_ch_vec_o[c][i] = valid_q[i] & (entry_q[i].op == HTU_READ)
                            & (entry_q[i].ch_id == 2'(c));
      end
    end
  end

  assign valid_vec_o   = valid_q;
  assign fill_ok_vec_o = ~fill_wait_q;

  // ------------------------------
  // selected entry to command
  // ------------------------------
  assign sel_req = entry_q[issue_ptr_i];

  always_comb begin
    cmd_o.ch_id          = sel_req.ch_id;
    cmd_o.rob_num        = sel_req.rob_id;
    cmd_o.set_way_offset = sel_req.set_way_offset;
    cmd_o.wbuffer_id     = sel_req.wbuffer_id;
    cmd_o.cl_state0      = sel_req.cl_state0;
    cmd_o.cl_state1      = sel_req.cl_state1;
    case (sel_req.op)
      HTU_EVICT: cmd_o.opcode = SC_WRITE_BACK;
      HTU_WRITE: cmd_o.opcode = SC_WRITE;
      default:   cmd_o.opcode = sel_req.need_linefill ? SC_READ_LINEFILL : SC_READ;
    endcase
  end

  // pointers come from the top, slot state lives here
  a_alloc_free_slot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    alloc_i |-> !valid_q[alloc_ptr_i]);

  a_issue_valid_slot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_i |-> valid_q[issue_ptr_i]);

endmodule

//--- hdl/bank_isu_credit_manage.sv
module bank_isu_credit_manage (
  input  logic                                                   clk_i,
  input  logic                                                   rst_n_i,
  input  logic                                                   issue_i,
  input  bank_isu_pkg::iq_ptr_t                                  issue_ptr_i,
  input  logic [bank_isu_pkg::NUM_CH-1:0][bank_isu_pkg::IQ_DEPTH-1:0] read_ch_vec_i,
  input  logic [bank_isu_pkg::NUM_CH-1:0]                        ch_pop_i,
  output logic [bank_isu_pkg::IQ_DEPTH-1:0]                      credit_ok_vec_o
);

  import bank_isu_pkg::*;

  localparam logic [CREDIT_WIDTH-1:0] CREDIT_FULL = CREDIT_WIDTH'(CH_CREDITS);

  logic [NUM_CH-1:0][CREDIT_WIDTH-1:0] credit_q;
  logic [NUM_CH-1:0]                   take;
  logic [NUM_CH-1:0]                   has_credit;

  // ------------------------------
  // credit counters
  // ------------------------------
  always_comb begin
    for (int c = 0; c < NUM_CH; c++) begin
      // issued entry was a read on channel c
      take[c]       = issue_i & read_ch_vec_i[c][issue_ptr_i];
      has_credit[c] = credit_q[c] != '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int c = 0; c < NUM_CH; c++) begin
        credit_q[c] <= CREDIT_FULL;
      end
    end else begin
      for (int c = 0; c < NUM_CH; c++) begin
        if (take[c] && !ch_pop_i[c]) begin
          credit_q[c] <= credit_q[c] - 1'b1;
        end else if (ch_pop_i[c] && !take[c]) begin
          credit_q[c] <= credit_q[c] + 1'b1;
        end
      end
    end
  end

  // ------------------------------
  // per-entry allow
  // ------------------------------
  // writes pass, reads need a credit on their own channel
  always_comb begin
    for (int i = 0; i < IQ_DEPTH; i++) begin
      credit_ok_vec_o[i] = 1'b1;
      for (int c = 0; c < NUM_CH; c++) begin
        if (read_ch_vec_i[c][i] && !has_credit[c]) begin
          credit_ok_vec_o[i] = 1'b0;
        end
      end
    end
  end

  for (genvar c = 0; c < NUM_CH; c++) begin : g_chk
    // buffer side must not return more than it was given
    a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (credit_q[c] <= CREDIT_FULL)
      && !(ch_pop_i[c] && !take[c] && credit_q[c] == CREDIT_FULL));
  end

endmodule

//--- hdl/shift_priority_arb.sv
module shift_priority_arb (
  input  logic [bank_isu_pkg::IQ_DEPTH-1:0] req_vec_i,
  input  bank_isu_pkg::iq_ptr_t             bottom_ptr_i,
  output bank_isu_pkg::iq_ptr_t             issue_ptr_o,
  output logic                              hit_o
);

  import bank_isu_pkg::*;

  logic [2*IQ_DEPTH-1:0] dbl_vec;
  logic [IQ_DEPTH-1:0]   rot_vec;
  iq_ptr_t               rot_idx;

  // rotate so the oldest slot lands on bit 0
  assign dbl_vec = {req_vec_i, req_vec_i} >> bottom_ptr_i;
  assign rot_vec = dbl_vec[IQ_DEPTH-1:0];

  // lowest set bit wins
  always_comb begin
    rot_idx = '0;
    for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
      if (rot_vec[i]) begin
        rot_idx = IQ_PTR_WIDTH'(i);
      end
    end
  end

  // back to a queue slot, wraps with the pointer width
  assign issue_ptr_o = rot_idx + bottom_ptr_i;
  assign hit_o       = |req_vec_i;

endmodule

//--- hdl/bank_isu_iq.sv
module bank_isu_iq (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // request from hit-test unit
  input  logic                              req_valid_i,
  input  bank_isu_pkg::isu_req_t            req_i,
  input  logic                              req_inflight_i,
  output logic                              req_allow_in_o,
  // bus interface read response
  input  logic                              biu_rvalid_i,
  input  logic [5:0]                        biu_rid_i,
  // sram controller command
  output logic                              sc_valid_o,
  output bank_isu_pkg::sc_cmd_t             sc_cmd_o,
  input  logic                              sc_ready_i,
  // channel credit return
  input  logic [bank_isu_pkg::NUM_CH-1:0]   ch_pop_i
);

  import bank_isu_pkg::*;

  localparam logic [IQ_PTR_WIDTH:0] OCC_FULL = (IQ_PTR_WIDTH + 1)'(IQ_DEPTH);

  iq_ptr_t                           alloc_ptr_q;
  iq_ptr_t                           bottom_ptr_q;
  logic [IQ_PTR_WIDTH:0]             occ_q;
  logic                              alloc;
  logic                              bottom_skip;
  logic                              issue;
  iq_ptr_t                           issue_ptr;
  logic                              issue_hit;
  logic [IQ_DEPTH-1:0]               valid_vec;
  logic [IQ_DEPTH-1:0]               fill_ok_vec;
  logic [IQ_DEPTH-1:0]               evict_vec;
  logic [NUM_CH-1:0][IQ_DEPTH-1:0]   read_ch_vec;
  logic [IQ_DEPTH-1:0]               credit_ok_vec;
  logic [IQ_DEPTH-1:0]               exec_vec;

  // ------------------------------
  // enqueue and dequeue pointers
  // ------------------------------
  assign req_allow_in_o = occ_q != OCC_FULL;
  assign alloc          = req_valid_i & req_allow_in_o;

  // free slots leave from the bottom one per cycle
  assign bottom_skip = (occ_q != '0) & ~valid_vec[bottom_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      alloc_ptr_q  <= '0;
      bottom_ptr_q <= '0;
      occ_q        <= '0;
    end else begin
      if (alloc) begin
        alloc_ptr_q <= alloc_ptr_q + 1'b1;
      end
      if (bottom_skip) begin
        bottom_ptr_q <= bottom_ptr_q + 1'b1;
      end
      if (alloc && !bottom_skip) begin
        occ_q <= occ_q + 1'b1;
      end else if (bottom_skip && !alloc) begin
        occ_q <= occ_q - 1'b1;
      end
    end
  end

  iq_array u_iq_array (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .alloc_i          (alloc),
    .alloc_ptr_i      (alloc_ptr_q),
    .alloc_req_i      (req_i),
    .alloc_inflight_i (req_inflight_i),
    .issue_i          (issue),
    .issue_ptr_i      (issue_ptr),
    .biu_rvalid_i     (biu_rvalid_i),
    .biu_rid_i        (biu_rid_i),
    .valid_vec_o      (valid_vec),
    .fill_ok_vec_o    (fill_ok_vec),
    .evict_vec_o      (evict_vec),
    .read_ch_vec_o    (read_ch_vec),
    .cmd_o            (sc_cmd_o)
  );

  bank_isu_credit_manage u_credit_manage (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .issue_i         (issue),
    .issue_ptr_i     (issue_ptr),
    .read_ch_vec_i   (read_ch_vec),
    .ch_pop_i        (ch_pop_i),
    .credit_ok_vec_o (credit_ok_vec)
  );

  // ------------------------------
  // issue select
  // ------------------------------
  // evicts skip both the line-fill and the credit wait
  assign exec_vec = valid_vec & ((fill_ok_vec & credit_ok_vec) | evict_vec);

  shift_priority_arb u_arb (
    .req_vec_i    (exec_vec),
    .bottom_ptr_i (bottom_ptr_q),
    .issue_ptr_o  (issue_ptr),
    .hit_o        (issue_hit)
  );

  assign sc_valid_o = issue_hit;
  assign issue      = sc_valid_o & sc_ready_i;

  // valid entries all sit inside the occupied window
  a_occ_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (occ_q <= OCC_FULL) && ($countones(valid_vec) <= occ_q));

endmodule

//--- bench/bank_isu_iq_tb.sv
module bank_isu_iq_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import bank_isu_pkg::*;

  localparam int NUM_TESTS = 6;
  localparam int WATCHDOG_NS = 40 * 200 * NUM_TESTS;

  logic              clk_i;
  logic              rst_n_i;
  logic              req_valid_i;
  isu_req_t          req_i;
  logic              req_inflight_i;
  logic              req_allow_in_o;
  logic              biu_rvalid_i;
  logic [5:0]        biu_rid_i;
  logic              sc_valid_o;
  sc_cmd_t           sc_cmd_o;
  logic              sc_ready_i;
  logic [NUM_CH-1:0] ch_pop_i = '0;

  int         seed = 99030;
  sc_cmd_t    exp_mem [0:63];
  logic [5:0] exp_wr;
  logic [5:0] exp_rd = '0;
  bit         auto_pop;
  int         man_pop_req [4];
  int         man_pop_done [4];
  int         auto_pend [4];
  int         chk_errs = 0;
  int         main_errs;
  int         tests_failed;

  bank_isu_iq bank_isu_iq_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // plain opcode mapping of a request to its command
  function automatic sc_cmd_t expected_cmd(isu_req_t r);
    sc_cmd_t c;
    c.ch_id          = r.ch_id;
    c.rob_num        = r.rob_id;
    c.set_way_offset = r.set_way_offset;
    c.wbuffer_id     = r.wbuffer_id;
    c.cl_state0      = r.cl_state0;
    c.cl_state1      = r.cl_state1;
    if (r.op == HTU_EVICT) c.opcode = SC_WRITE_BACK;
    else if (r.op == HTU_WRITE) c.opcode = SC_WRITE;
    else if (r.need_linefill) c.opcode = SC_READ_LINEFILL;
    else c.opcode = SC_READ;
    return c;
  endfunction

  function automatic isu_req_t rand_req(htu_op_e op, logic [1:0] ch, logic lf);
    isu_req_t r;
    int a;
    a = $random(seed);
    r.op = op;
    r.ch_id = ch;
    r.rob_id = a[2:0];
    r.set_way_offset = a[9:3];
    r.wbuffer_id = a[17:10];
    r.cl_state0 = a[19:18];
    r.cl_state1 = a[21:20];
    r.need_linefill = lf;
    return r;
  endfunction

  task automatic check_cmd(input sc_cmd_t got, input sc_cmd_t exp, input string msg,
                           output bit ok);
    ok = (got === exp);
    if (!ok) $display("mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
  endtask

  task automatic check_flag(input logic got, input logic exp, input string msg,
                            output bit ok);
    ok = (got === exp);
    if (!ok) $display("mismatch at %0t: %s, got %b expected %b", $time, msg, got, exp);
  endtask

  // ------------------------------
  // checker and credit return
  // ------------------------------
  always @(posedge clk_i) begin : issue_monitor
    logic [NUM_CH-1:0] pop;
    bit ok;
    pop = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      if (man_pop_req[c] > man_pop_done[c]) begin
        pop[c] = 1'b1;
        man_pop_done[c]++;
      end else if (auto_pend[c] > 0) begin
        pop[c] = 1'b1;
        auto_pend[c]--;
      end
    end
    ch_pop_i <= pop;
    if (rst_n_i && sc_valid_o && sc_ready_i) begin
      if (exp_rd == exp_wr) begin
        $display("error at %0t: a command issued while none was expected", $time);
        chk_errs++;
      end else begin
        check_cmd(sc_cmd_o, exp_mem[exp_rd], "issued command", ok);
        if (!ok) chk_errs++;
        exp_rd = exp_rd + 1'b1;
      end
      // channel buffer hands the credit back a cycle later
      if (auto_pop && (sc_cmd_o.opcode == SC_READ || sc_cmd_o.opcode == SC_READ_LINEFILL)
          && sc_cmd_o.ch_id != 2'd3) begin
        auto_pend[sc_cmd_o.ch_id]++;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("error: run did not finish within %0d ns", WATCHDOG_NS);
    $display("*** FAILED ***");
    $finish;
  end

  // ------------------------------
  // stimulus helpers
  // ------------------------------
  task automatic expect_req(isu_req_t r);
    exp_mem[exp_wr] = expected_cmd(r);
    exp_wr = exp_wr + 1'b1;
  endtask

  task automatic send(isu_req_t r, logic inflight);
    req_valid_i    <= 1'b1;
    req_i          <= r;
    req_inflight_i <= inflight;
    do @(posedge clk_i); while (!req_allow_in_o);
  endtask

  task automatic idle(int n);
    req_valid_i    <= 1'b0;
    req_inflight_i <= 1'b0;
    repeat (n) @(posedge clk_i);
  endtask

  task automatic flag(logic got, logic exp, string msg);
    bit ok;
    check_flag(got, exp, msg, ok);
    if (!ok) main_errs++;
  endtask

  // wait until only `left` expected commands remain
  task automatic wait_left(logic [5:0] left, int limit, string what);
    int n;
    n = 0;
    while (6'(exp_wr - exp_rd) > left && n < limit) begin
      @(posedge clk_i);
      n++;
    end
    if (6'(exp_wr - exp_rd) > left) begin
      $display("error: %s did not issue in %0d cycles", what, limit);
      main_errs++;
    end
  endtask

  task automatic biu_pulse(logic [5:0] rid);
    biu_rvalid_i <= 1'b1;
    biu_rid_i    <= rid;
    @(posedge clk_i);
    biu_rvalid_i <= 1'b0;
  endtask

  task automatic finish_test(string name, int errs_before);
    if (chk_errs + main_errs != errs_before) begin
      tests_failed++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  initial begin : main
    isu_req_t r0;
    isu_req_t r1;
    isu_req_t r2;
    bit       ok;
    int       e0;
    int       k;
    exp_wr = '0;
    main_errs = 0;
    tests_failed = 0;
    auto_pop = 1'b1;
    rst_n_i = 1'b0;
    req_valid_i = 1'b0;
    req_i = '0;
    req_inflight_i = 1'b0;
    biu_rvalid_i = 1'b0;
    biu_rid_i = '0;
    sc_ready_i = 1'b1;
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    flag(sc_valid_o, 1'b0, "sc_valid_o after reset");
    flag(req_allow_in_o, 1'b1, "req_allow_in_o after reset");

    // random mix in arrival order
    e0 = chk_errs + main_errs;
    for (int i = 0; i < 24; i++) begin
      k = $unsigned($random(seed)) % 3;
      r0 = rand_req(k == 0 ? HTU_WRITE : HTU_READ, 2'($unsigned($random(seed)) % 3), k == 2);
      expect_req(r0);
      send(r0, 1'b0);
    end
    idle(1);
    wait_left(0, 100, "random requests");
    finish_test("random_mix", e0);

    // fill the queue under back-pressure
    e0 = chk_errs + main_errs;
    sc_ready_i <= 1'b0;
    for (int i = 0; i < IQ_DEPTH; i++) begin
      r0 = rand_req(HTU_WRITE, 2'd0, 1'b0);
      expect_req(r0);
      send(r0, 1'b0);
    end
    idle(2);
    flag(req_allow_in_o, 1'b0, "req_allow_in_o with full queue");
    sc_ready_i <= 1'b1;
    wait_left(0, 100, "queued writes");
    k = 0;
    while (!req_allow_in_o && k < 20) begin
      @(posedge clk_i);
      k++;
    end
    flag(req_allow_in_o, 1'b1, "req_allow_in_o after drain");
    finish_test("full_queue", e0);

    // line fill wait, younger write passes
    e0 = chk_errs + main_errs;
    idle(5);
    r0 = rand_req(HTU_READ, 2'd1, 1'b1);
    r1 = rand_req(HTU_WRITE, 2'd2, 1'b0);
    expect_req(r1);
    expect_req(r0);
    send(r0, 1'b1);
    send(r1, 1'b0);
    idle(1);
    wait_left(1, 50, "write behind a line fill");
    idle(8);
    flag(sc_valid_o, 1'b0, "sc_valid_o while line fill pending");
    biu_pulse(r0.set_way_offset[5:0] ^ 6'h01);
    idle(5);
    flag(6'(exp_wr - exp_rd) == 6'd1, 1'b1, "read still waiting after non-matching rid");
    biu_pulse(r0.set_way_offset[5:0]);
    wait_left(0, 50, "read after line fill");
    finish_test("line_fill", e0);

    // credits on channel 0
    e0 = chk_errs + main_errs;
    idle(5);
    auto_pop = 1'b0;
    for (int i = 0; i < 3; i++) begin
      r0 = rand_req(HTU_READ, 2'd0, 1'b0);
      expect_req(r0);
      send(r0, 1'b0);
    end
    idle(1);
    wait_left(1, 50, "reads within credit");
    idle(10);
    flag(6'(exp_wr - exp_rd) == 6'd1, 1'b1, "third read held with no credit");
    man_pop_req[0]++;
    wait_left(0, 50, "read after credit return");
    finish_test("credits", e0);

    // evict ignores credits and line fill
    e0 = chk_errs + main_errs;
    r0 = rand_req(HTU_READ, 2'd0, 1'b0);
    r1 = rand_req(HTU_READ, 2'd1, 1'b1);
    r2 = rand_req(HTU_EVICT, 2'd0, 1'b0);
    expect_req(r2);
    send(r0, 1'b0);
    send(r1, 1'b1);
    send(r2, 1'b1);
    idle(1);
    wait_left(0, 50, "evict");
    idle(5);
    flag(sc_valid_o, 1'b0, "sc_valid_o with blocked reads");
    auto_pop = 1'b1;
    expect_req(r0);
    man_pop_req[0]++;
    wait_left(0, 50, "blocked read on channel 0");
    expect_req(r1);
    biu_pulse(r1.set_way_offset[5:0]);
    wait_left(0, 50, "blocked line fill read");
    man_pop_req[0]++;
    finish_test("evict", e0);

    // command holds under back-pressure
    e0 = chk_errs + main_errs;
    idle(5);
    sc_ready_i <= 1'b0;
    r0 = rand_req(HTU_WRITE, 2'd0, 1'b0);
    r1 = rand_req(HTU_WRITE, 2'd2, 1'b0);
    send(r0, 1'b0);
    send(r1, 1'b0);
    idle(3);
    check_cmd(sc_cmd_o, expected_cmd(r0), "command under back-pressure", ok);
    if (!ok) main_errs++;
    repeat (20) begin
      @(posedge clk_i);
      flag(sc_valid_o, 1'b1, "sc_valid_o under back-pressure");
      check_cmd(sc_cmd_o, expected_cmd(r0), "held command", ok);
      if (!ok) main_errs++;
    end
    expect_req(r0);
    expect_req(r1);
    sc_ready_i <= 1'b1;
    wait_left(0, 50, "held writes");
    finish_test("back_pressure", e0);

    idle(5);
    $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed,
             chk_errs + main_errs);
    if (chk_errs + main_errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- filelist.f
hdl/bank_isu_pkg.sv
hdl/iq_array.sv
hdl/bank_isu_credit_manage.sv
hdl/shift_priority_arb.sv
hdl/bank_isu_iq.sv
bench/bank_isu_iq_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the issue queue testbench with Verilator
verilator --binary --timing --assert -f filelist.f --top-module bank_isu_iq_tb -o sim \
  || { echo "build failed"; exit 1; }
./obj_dir/sim > sim.log 2>&1
cat sim.log
grep -qF '*** PASSED ***' sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
